// File: source/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// Datapath sizes
	localparam int dataWidth = 16;
	localparam int regAddrWidth = 4;
	localparam int imemDepth = 256;
	localparam int dmemDepth = 256;
	localparam int imemAddrWidth = $clog2(imemDepth);
	localparam int dmemAddrWidth = $clog2(dmemDepth);

	// Opcode 0011 has no instruction, so this word flows as a no-op
	localparam logic [dataWidth-1:0] nopWord = 16'h3000;

	// Forwarding selects for the execute operands
	localparam logic [1:0] fwdReg = 2'd0;
	localparam logic [1:0] fwdWb = 2'd1;
	localparam logic [1:0] fwdMem = 2'd2;

	// Gaps in the encoding decode as no-ops
	typedef enum logic [3:0] {
		ADD = 4'b0000,
		SUB = 4'b0001,
		XOR = 4'b0010,
		SLL = 4'b0100,
		SRA = 4'b0101,
		LW = 4'b1000,
		SW = 4'b1001,
		LLB = 4'b1010,
		B = 4'b1100,
		BR = 4'b1101,
		PCS = 4'b1110,
		HLT = 4'b1111
	} opcodeT;

	// Branch condition in bits 11 to 9
	typedef enum logic [2:0] {
		NE, EQ, GT, LT, GE, LE, OV, ALWAYS
	} condT;

	// Writeback source
	typedef enum logic [1:0] {
		fromAlu, fromMem, fromImm, fromPcs
	} dataSrcT;

	typedef struct packed {
		logic n;
		logic v;
		logic z;
	} flagsT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic aluSrcImm;
		logic setsFlags;
		logic halt;
		dataSrcT dataSrc;
	} ctrlT;

	typedef struct packed {
		logic [dataWidth-1:0] instr;
		logic [dataWidth-1:0] pcNext;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		opcodeT op;
		logic [regAddrWidth-1:0] rd;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [dataWidth-1:0] rsData;
		logic [dataWidth-1:0] rtData;
		logic [dataWidth-1:0] imm;
		logic [dataWidth-1:0] pcNext;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		logic [regAddrWidth-1:0] rd;
		logic [dataWidth-1:0] aluOut;
		logic [dataWidth-1:0] storeData;
		logic [dataWidth-1:0] imm;
		logic [dataWidth-1:0] pcNext;
	} exMemT;

	typedef struct packed {
		ctrlT ctrl;
		logic [regAddrWidth-1:0] rd;
		logic [dataWidth-1:0] aluOut;
		logic [dataWidth-1:0] memOut;
		logic [dataWidth-1:0] imm;
		logic [dataWidth-1:0] pcNext;
	} memWbT;

	// Register write as seen from outside
	typedef struct packed {
		logic en;
		logic [regAddrWidth-1:0] rd;
		logic [dataWidth-1:0] data;
	} wbEventT;

endpackage

`default_nettype wire

// File: source/fetch.sv
`default_nettype none
`timescale 1ns/100ps

module fetch (
	input logic clk,
	input logic arstN,
	input logic stall,
	input logic branchTaken,
	input logic [cpuPkg::dataWidth-1:0] branchTarget,
	output logic [cpuPkg::dataWidth-1:0] pc,
	output logic [cpuPkg::dataWidth-1:0] instr,
	output logic [cpuPkg::dataWidth-1:0] pcNext
);

	logic [cpuPkg::dataWidth-1:0] imem [cpuPkg::imemDepth];
	logic [cpuPkg::dataWidth-1:0] pcUpdate;
	logic isHalt;

	// Program image
	initial begin
		$readmemh("program.hex", imem);
	end

	// Word addressed on the low pc bits
	assign instr = imem[pc[cpuPkg::imemAddrWidth-1:0]];
	assign pcNext = pc + cpuPkg::dataWidth'(1);
	assign isHalt = instr[15:12] == cpuPkg::HLT;

	// Taken branch beats both stall and HLT
	always_comb begin
		if (branchTaken) begin
			pcUpdate = branchTarget;
		end else if (stall || isHalt) begin
			pcUpdate = pc;
		end else begin
			pcUpdate = pcNext;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else begin
			pc <= pcUpdate;
		end
	end

endmodule

`default_nettype wire

// File: source/hazardControl.sv
`default_nettype none
`timescale 1ns/100ps

module hazardControl (
	input logic [cpuPkg::dataWidth-1:0] instrIf,
	input cpuPkg::ifIdT ifId,
	input cpuPkg::idExT idEx,
	input cpuPkg::exMemT exMem,
	input cpuPkg::memWbT memWb,
	input logic branchTaken,
	output logic stall,
	output logic squash,
	output logic bubble,
	output logic [1:0] forwardA,
	output logic [1:0] forwardB
);

	cpuPkg::opcodeT decOp;
	logic [cpuPkg::regAddrWidth-1:0] decRs;
	logic [cpuPkg::regAddrWidth-1:0] decRt;
	logic usesRs, usesRt;
	logic loadUse, flagWait, regWait, haltRepeat;

	// Memory stage first, then writeback, then the register value
	function automatic logic [1:0] fwdSel(input logic [cpuPkg::regAddrWidth-1:0] src);
		if (exMem.ctrl.regWrite && exMem.rd == src) return cpuPkg::fwdMem;
		if (memWb.ctrl.regWrite && memWb.rd == src) return cpuPkg::fwdWb;
		return cpuPkg::fwdReg;
	endfunction

	// Sources of the instruction in decode
	assign decOp = cpuPkg::opcodeT'(ifId.instr[15:12]);
	assign decRs = ifId.instr[7:4];
	// SW reads rd as its store data
	assign decRt = (decOp == cpuPkg::SW) ? ifId.instr[11:8] : ifId.instr[3:0];
	assign usesRs = decOp inside {cpuPkg::ADD, cpuPkg::SUB, cpuPkg::XOR, cpuPkg::SLL,
		cpuPkg::SRA, cpuPkg::LW, cpuPkg::SW, cpuPkg::BR};
	assign usesRt = decOp inside {cpuPkg::ADD, cpuPkg::SUB, cpuPkg::XOR, cpuPkg::SW};

	// Load in execute feeding decode
	assign loadUse = idEx.ctrl.memRead
		&& ((usesRs && idEx.rd == decRs) || (usesRt && idEx.rd == decRt));
	// Flags land at the end of execute
	assign flagWait = decOp == cpuPkg::B && idEx.ctrl.setsFlags;
	// BR target register still in flight
	assign regWait = decOp == cpuPkg::BR
		&& ((idEx.ctrl.regWrite && idEx.rd == decRs)
		|| (exMem.ctrl.regWrite && exMem.rd == decRs));

	assign stall = loadUse || flagWait || regWait;
	assign bubble = stall;

	// Squash a held HLT refetched behind the copy in decode
	assign haltRepeat = instrIf[15:12] == cpuPkg::HLT && decOp == cpuPkg::HLT;
	assign squash = !stall && (branchTaken || haltRepeat);

	assign forwardA = fwdSel(idEx.rs);
	assign forwardB = fwdSel(idEx.rt);

endmodule

`default_nettype wire

// File: source/decode.sv
`default_nettype none
`timescale 1ns/100ps

module decode (
	input logic clk,
	input logic arstN,
	input cpuPkg::ifIdT ifId,
	input cpuPkg::flagsT flags,
	input cpuPkg::wbEventT wbEvent,
	output cpuPkg::idExT idEx,
	output logic branchTaken,
	output logic [cpuPkg::dataWidth-1:0] branchTarget
);

	cpuPkg::opcodeT op;
	cpuPkg::ctrlT ctrl;
	logic [cpuPkg::regAddrWidth-1:0] rd, rs, rtSel;
	logic [cpuPkg::dataWidth-1:0] rsData, rtData, imm;
	logic [cpuPkg::dataWidth-1:0] regFile [2**cpuPkg::regAddrWidth];
	logic condOk;

	// Condition code against N, V, Z
	function automatic logic condTest(input cpuPkg::condT c, input cpuPkg::flagsT f);
		case (c)
			cpuPkg::NE: return !f.z;
			cpuPkg::EQ: return f.z;
			cpuPkg::GT: return !f.z && !f.n;
			cpuPkg::LT: return f.n;
			cpuPkg::GE: return !f.n;
			cpuPkg::LE: return f.n || f.z;
			cpuPkg::OV: return f.v;
			default: return 1'b1;
		endcase
	endfunction

	assign op = cpuPkg::opcodeT'(ifId.instr[15:12]);
	assign rd = ifId.instr[11:8];
	assign rs = ifId.instr[7:4];
	assign rtSel = (op == cpuPkg::SW) ? rd : ifId.instr[3:0];

	// Control word, unused opcodes stay all zero
	always_comb begin
		ctrl = '0;
		ctrl.dataSrc = cpuPkg::fromAlu;
		case (op)
			cpuPkg::ADD, cpuPkg::SUB, cpuPkg::XOR: begin
				ctrl.regWrite = 1'b1;
				ctrl.setsFlags = 1'b1;
			end
			cpuPkg::SLL, cpuPkg::SRA: begin
				ctrl.regWrite = 1'b1;
				ctrl.setsFlags = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			cpuPkg::LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.dataSrc = cpuPkg::fromMem;
			end
			cpuPkg::SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			cpuPkg::LLB: begin
				ctrl.regWrite = 1'b1;
				ctrl.dataSrc = cpuPkg::fromImm;
			end
			cpuPkg::PCS: begin
				ctrl.regWrite = 1'b1;
				ctrl.dataSrc = cpuPkg::fromPcs;
			end
			cpuPkg::HLT: ctrl.halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// Immediate by opcode
	always_comb begin
		case (op)
			// Shift amount is unsigned
			cpuPkg::SLL, cpuPkg::SRA: imm = {12'b0, ifId.instr[3:0]};
			cpuPkg::LW, cpuPkg::SW: imm = {{12{ifId.instr[3]}}, ifId.instr[3:0]};
			cpuPkg::LLB: imm = {{8{ifId.instr[7]}}, ifId.instr[7:0]};
			// Word offset of B
			default: imm = {{7{ifId.instr[8]}}, ifId.instr[8:0]};
		endcase
	end

	// Register file
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 2**cpuPkg::regAddrWidth; i++) regFile[i] <= '0;
		end else if (wbEvent.en) begin
			regFile[wbEvent.rd] <= wbEvent.data;
		end
	end

	// Write-through reads
	assign rsData = (wbEvent.en && wbEvent.rd == rs) ? wbEvent.data : regFile[rs];
	assign rtData = (wbEvent.en && wbEvent.rd == rtSel) ? wbEvent.data : regFile[rtSel];

	// Branch resolution
	assign condOk = condTest(cpuPkg::condT'(ifId.instr[11:9]), flags);
	assign branchTaken = (op == cpuPkg::B || op == cpuPkg::BR) && condOk;
	assign branchTarget = (op == cpuPkg::BR) ? rsData : ifId.pcNext + imm;

	assign idEx = '{ctrl: ctrl, op: op, rd: rd, rs: rs, rt: rtSel, rsData: rsData,
		rtData: rtData, imm: imm, pcNext: ifId.pcNext};

endmodule

`default_nettype wire

// File: source/execute.sv
`default_nettype none
`timescale 1ns/100ps

module execute (
	input logic clk,
	input logic arstN,
	input cpuPkg::idExT idEx,
	input logic [1:0] forwardA,
	input logic [1:0] forwardB,
	input logic [cpuPkg::dataWidth-1:0] memAlu,
	input logic [cpuPkg::dataWidth-1:0] wbData,
	output cpuPkg::flagsT flags,
	output cpuPkg::exMemT exMem
);

	logic [cpuPkg::dataWidth-1:0] opA, regB, opB, result;
	logic overflow;

	// Operand source
	function automatic logic [cpuPkg::dataWidth-1:0] fwdMux(input logic [1:0] sel,
		input logic [cpuPkg::dataWidth-1:0] regVal);
		case (sel)
			cpuPkg::fwdMem: return memAlu;
			cpuPkg::fwdWb: return wbData;
			default: return regVal;
		endcase
	endfunction

	assign opA = fwdMux(forwardA, idEx.rsData);
	// Also the store data of SW
	assign regB = fwdMux(forwardB, idEx.rtData);
	assign opB = idEx.ctrl.aluSrcImm ? idEx.imm : regB;

	// ALU
	always_comb begin
		overflow = 1'b0;
		case (idEx.op)
			cpuPkg::ADD: begin
				result = opA + opB;
				overflow = (opA[15] == opB[15]) && (result[15] != opA[15]);
			end
			cpuPkg::SUB: begin
				result = opA - opB;
				overflow = (opA[15] != opB[15]) && (result[15] != opA[15]);
			end
			cpuPkg::XOR: result = opA ^ opB;
			cpuPkg::SLL: result = opA << opB[3:0];
			cpuPkg::SRA: result = $signed(opA) >>> opB[3:0];
			// LW and SW address
			default: result = opA + opB;
		endcase
	end

	// Flags written only by flag-setting ops
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			flags <= '0;
		end else if (idEx.ctrl.setsFlags) begin
			flags <= '{n: result[15], v: overflow, z: result == '0};
		end
	end

	assign exMem = '{ctrl: idEx.ctrl, rd: idEx.rd, aluOut: result, storeData: regB,
		imm: idEx.imm, pcNext: idEx.pcNext};

endmodule

`default_nettype wire

// File: source/dataMemory.sv
`default_nettype none
`timescale 1ns/100ps

module dataMemory (
	input logic clk,
	input logic [cpuPkg::dataWidth-1:0] addr,
	input logic [cpuPkg::dataWidth-1:0] writeData,
	input logic write,
	output logic [cpuPkg::dataWidth-1:0] readData
);

	logic [cpuPkg::dataWidth-1:0] mem [cpuPkg::dmemDepth];
	logic [cpuPkg::dmemAddrWidth-1:0] index;

	// Low address bits only
	assign index = addr[cpuPkg::dmemAddrWidth-1:0];

	always_ff @(posedge clk) begin
		if (write) begin
			mem[index] <= writeData;
		end
	end

	// Read is combinational, ready within the memory stage
	assign readData = mem[index];

endmodule

`default_nettype wire

// File: source/cpu.sv
`default_nettype none
`timescale 1ns/100ps

module cpu (
	input logic clk,
	input logic arstN,
	output logic [cpuPkg::dataWidth-1:0] pc,
	output logic hlt,
	output cpuPkg::wbEventT wbEvent
);

	// Fetch side
	logic [cpuPkg::dataWidth-1:0] instrIf, pcNextIf;
	logic redirect;

	// Pipeline registers and their inputs
	cpuPkg::ifIdT ifId;
	cpuPkg::idExT idExNext, idEx;
	cpuPkg::exMemT exMemNext, exMem;
	cpuPkg::memWbT memWb;

	// Hazard and branch strobes
	logic stall, squash, bubble;
	logic [1:0] forwardA, forwardB;
	logic branchTaken;
	logic [cpuPkg::dataWidth-1:0] branchTarget;

	cpuPkg::flagsT flags;
	logic [cpuPkg::dataWidth-1:0] memOut, memFwd, wbData;
	logic halted;

	// Branch waits out a stall in decode
	assign redirect = branchTaken && !stall;

	fetch i_fetch (.clk(clk), .arstN(arstN), .stall(stall), .branchTaken(redirect),
		.branchTarget(branchTarget), .pc(pc), .instr(instrIf), .pcNext(pcNextIf));

	hazardControl i_hazardControl (.instrIf(instrIf), .ifId(ifId), .idEx(idEx),
		.exMem(exMem), .memWb(memWb), .branchTaken(branchTaken), .stall(stall),
		.squash(squash), .bubble(bubble), .forwardA(forwardA), .forwardB(forwardB));

	// IF/ID, held on stall, no-op on squash
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ifId <= '{instr: cpuPkg::nopWord, pcNext: '0};
		end else if (squash) begin
			ifId <= '{instr: cpuPkg::nopWord, pcNext: pcNextIf};
		end else if (!stall) begin
			ifId <= '{instr: instrIf, pcNext: pcNextIf};
		end
	end

	decode i_decode (.clk(clk), .arstN(arstN), .ifId(ifId), .flags(flags),
		.wbEvent(wbEvent), .idEx(idExNext), .branchTaken(branchTaken),
		.branchTarget(branchTarget));

	// ID/EX, bubble keeps the data but kills the control
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			idEx <= '0;
		end else begin
			idEx <= idExNext;
			if (bubble) idEx.ctrl <= '0;
		end
	end

	// What the memory stage will write back
	always_comb begin
		case (exMem.ctrl.dataSrc)
			cpuPkg::fromImm: memFwd = exMem.imm;
			cpuPkg::fromPcs: memFwd = exMem.pcNext;
			default: memFwd = exMem.aluOut;
		endcase
	end

	execute i_execute (.clk(clk), .arstN(arstN), .idEx(idEx), .forwardA(forwardA),
		.forwardB(forwardB), .memAlu(memFwd), .wbData(wbData), .flags(flags),
		.exMem(exMemNext));

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) exMem <= '0;
		else exMem <= exMemNext;
	end

	dataMemory i_dataMemory (.clk(clk), .addr(exMem.aluOut), .writeData(exMem.storeData),
		.write(exMem.ctrl.memWrite), .readData(memOut));

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			memWb <= '0;
		end else begin
			memWb <= '{ctrl: exMem.ctrl, rd: exMem.rd, aluOut: exMem.aluOut, memOut: memOut,
				imm: exMem.imm, pcNext: exMem.pcNext};
		end
	end

	// Writeback select
	always_comb begin
		case (memWb.ctrl.dataSrc)
			cpuPkg::fromMem: wbData = memWb.memOut;
			cpuPkg::fromImm: wbData = memWb.imm;
			cpuPkg::fromPcs: wbData = memWb.pcNext;
			default: wbData = memWb.aluOut;
		endcase
	end

	assign wbEvent = '{en: memWb.ctrl.regWrite, rd: memWb.rd, data: wbData};

	// Sticky until reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) halted <= 1'b0;
		else if (memWb.ctrl.halt) halted <= 1'b1;
	end

	assign hlt = halted;

endmodule

`default_nettype wire

// File: tb/cpuTb.sv
`default_nettype none
`timescale 1ns/100ps

module cpuTb;

	localparam int clkPeriod = 20;
	localparam int resetCycles = 4;
	localparam int numWrites = 22;
	// Fetch in cycle 0, writeback event in cycle 4
	localparam int firstWbCycle = 4;
	localparam int tailCycles = 10;
	localparam int watchdogCycles = numWrites * 8 + 100;
	// Address of the HLT word in program.hex
	localparam logic [cpuPkg::dataWidth-1:0] haltPc = 16'h001E;

	// One expected register write
	typedef struct packed {
		logic [cpuPkg::regAddrWidth-1:0] rd;
		logic [cpuPkg::dataWidth-1:0] data;
	} writeT;

	logic clk;
	logic arstN;
	logic [cpuPkg::dataWidth-1:0] pc;
	logic hlt;
	cpuPkg::wbEventT wbEvent;

	writeT expected [numWrites];
	int errors;
	int checks;
	int cycles;

	cpu i_dut (
		.clk(clk),
		.arstN(arstN),
		.pc(pc),
		.hlt(hlt),
		.wbEvent(wbEvent)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Compare and report a mismatch in hex
	task automatic checkValue(input string name, input logic [15:0] actual,
		input logic [15:0] want);
		checks++;
		if (actual !== want) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, actual, want);
		end
	endtask

	// Writes in program order, skipped instructions absent
	task automatic loadTable();
		// Arithmetic chain with forwarding
		expected[0] = '{rd: 4'd1, data: 16'h0005};
		expected[1] = '{rd: 4'd2, data: 16'h0003};
		expected[2] = '{rd: 4'd3, data: 16'h0008};
		expected[3] = '{rd: 4'd4, data: 16'h0003};
		expected[4] = '{rd: 4'd5, data: 16'h000B};
		expected[5] = '{rd: 4'd6, data: 16'h002C};
		expected[6] = '{rd: 4'd7, data: 16'h0016};
		// Negative value through SRA
		expected[7] = '{rd: 4'd8, data: 16'hFF80};
		expected[8] = '{rd: 4'd9, data: 16'hFFF0};
		// Base address, then SW writes nothing
		expected[9] = '{rd: 4'd10, data: 16'h0010};
		// LW then dependent ADD after one bubble
		expected[10] = '{rd: 4'd11, data: 16'h0016};
		expected[11] = '{rd: 4'd12, data: 16'h001B};
		// SUB of equal values, B EQ skips r14 = 0x77
		expected[12] = '{rd: 4'd13, data: 16'h0000};
		expected[13] = '{rd: 4'd14, data: 16'h0011};
		// B NE not taken, next LLB lands
		expected[14] = '{rd: 4'd15, data: 16'h0022};
		// Build 0x4000, overflow to 0x8000, B OV skips r13 = 0x55
		expected[15] = '{rd: 4'd0, data: 16'h0001};
		expected[16] = '{rd: 4'd0, data: 16'h4000};
		expected[17] = '{rd: 4'd0, data: 16'h8000};
		// PCS at address 24
		expected[18] = '{rd: 4'd3, data: 16'h0019};
		expected[19] = '{rd: 4'd4, data: 16'h0004};
		// BR target 29, skips r2 = 0x66
		expected[20] = '{rd: 4'd3, data: 16'h001D};
		expected[21] = '{rd: 4'd2, data: 16'h0044};
	endtask

	task automatic printCounts();
		$display("Checks: %0d, errors: %0d", checks, errors);
	endtask

	// Main sequence, outputs sampled mid-cycle
	initial begin
		errors = 0;
		checks = 0;
		cycles = 0;
		arstN = 1'b0;
		loadTable();
		repeat (resetCycles) @(negedge clk);

		// State while still in reset
		checkValue("pc", pc, 16'h0000);
		checkValue("hlt", 16'(hlt), 16'h0000);
		checkValue("wbEvent.en", 16'(wbEvent.en), 16'h0000);
		arstN = 1'b1;

		// Walk the table, one entry per writeback event
		for (int i = 0; i < numWrites; i++) begin
			@(negedge clk);
			cycles++;
			while (wbEvent.en !== 1'b1) begin
				if (i == 0) begin
					checkValue("hlt", 16'(hlt), 16'h0000);
				end
				@(negedge clk);
				cycles++;
			end
			// Nothing may complete before the first instruction
			if (i == 0) begin
				checkValue("first writeback cycle", 16'(cycles), 16'(firstWbCycle));
			end
			checkValue("wbEvent.rd", 16'(wbEvent.rd), 16'(expected[i].rd));
			checkValue("wbEvent.data", wbEvent.data, expected[i].data);
		end

		// No stray writes before the halt shows up
		@(negedge clk);
		while (hlt !== 1'b1) begin
			checkValue("wbEvent.en", 16'(wbEvent.en), 16'h0000);
			@(negedge clk);
		end
		checkValue("pc", pc, haltPc);

		// Halted core stays quiet
		repeat (tailCycles) begin
			@(negedge clk);
			checkValue("wbEvent.en", 16'(wbEvent.en), 16'h0000);
			checkValue("hlt", 16'(hlt), 16'h0001);
			checkValue("pc", pc, haltPc);
		end

		printCounts();
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("Timeout: the processor never halted within %0d cycles", watchdogCycles);
		printCounts();
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: program.hex
// One instruction word per line, address 0 first
// Fields: opcode rd rs rt, B uses cond in bits 11..9 and a 9-bit offset
A105 // 00 LLB r1, 0x05
A203 // 01 LLB r2, 0x03
0312 // 02 ADD r3, r1, r2
1431 // 03 SUB r4, r3, r1
2543 // 04 XOR r5, r4, r3
4652 // 05 SLL r6, r5, 2
5761 // 06 SRA r7, r6, 1
A880 // 07 LLB r8, 0x80
5983 // 08 SRA r9, r8, 3
AA10 // 09 LLB r10, 0x10
97A2 // 0A SW r7, 2(r10)
8BA2 // 0B LW r11, 2(r10)
0CB1 // 0C ADD r12, r11, r1
1D11 // 0D SUB r13, r1, r1
C201 // 0E B EQ +1
AE77 // 0F LLB r14, 0x77 skipped
AE11 // 10 LLB r14, 0x11
C001 // 11 B NE +1 not taken
AF22 // 12 LLB r15, 0x22
A001 // 13 LLB r0, 0x01
400E // 14 SLL r0, r0, 14
0000 // 15 ADD r0, r0, r0
CC01 // 16 B OV +1
AD55 // 17 LLB r13, 0x55 skipped
E300 // 18 PCS r3
A404 // 19 LLB r4, 0x04
0334 // 1A ADD r3, r3, r4
DE30 // 1B BR ALWAYS r3
A266 // 1C LLB r2, 0x66 skipped
A244 // 1D LLB r2, 0x44
F000 // 1E HLT

// File: src.f
source/cpuPkg.sv
source/fetch.sv
source/hazardControl.sv
source/decode.sv
source/execute.sv
source/dataMemory.sv
source/cpu.sv
tb/cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Run from the project root so that program.hex is found
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --top-module cpuTb -f src.f --Mdir build -o cpuSim \
	&& ./build/cpuSim | tee sim.log \
	|| { echo "Build or simulation failed"; exit 1; }
grep -q "Everything OK" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
